// File: serial_alloc_pkg.sv
// ########################################
// fixed four lanes of eight bits each, a link word is always four bytes
// buffers hold one word plus the largest leftover chunk
// ########################################

package serial_alloc_pkg;

  // physical lanes and their width
  localparam int NUM_CHANNELS = 4;
  localparam int LANE_W       = 8;

  // link layer word size in bytes, byte 0 goes out first
  localparam int WORD_BYTES = 4;

  // one full word plus up to three leftover bytes
  localparam int BUF_BYTES = 7;

  // idle counters for auto-flush
  localparam int FLUSH_CNT_W = 8;

  // derived widths for buffer fill levels and lane indices
  localparam int BUF_CNT_W  = $clog2(BUF_BYTES + 1);
  localparam int LANE_IDX_W = $clog2(NUM_CHANNELS);

  typedef logic [LANE_W-1:0]              lane_t;
  typedef lane_t [NUM_CHANNELS-1:0]       lane_vec_t;
  typedef logic [NUM_CHANNELS-1:0]        chan_mask_t;
  typedef logic [WORD_BYTES*LANE_W-1:0]   link_word_t;
  typedef logic [FLUSH_CNT_W-1:0]         flush_cnt_t;

  // rx alignment, either waiting for lanes or holding a partial transfer
  typedef enum logic [0:0] {
    rx_wait,
    rx_partial
  } rx_sync_state_e;

endpackage

// File: tx_chopper.sv
// ########################################
// chunk size follows the enabled lane count, changing it mid-stream is unsafe
// with no lane enabled nothing is ever sent
// ########################################
`timescale 1ns/1ps

module tx_chopper
  import serial_alloc_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  chan_mask_t tx_channel_en_i,
  input  logic       tx_auto_flush_en_i,
  input  flush_cnt_t tx_auto_flush_count_i,
  input  logic       tx_flush_i,
  input  link_word_t word_i,
  input  logic       word_valid_i,
  output logic       word_ready_o,
  output lane_vec_t  chunk_o,
  output chan_mask_t chunk_mask_o,
  output logic       chunk_valid_o,
  input  logic       chunk_ready_i
);

  lane_t                buf_q [BUF_BYTES];
  lane_t                buf_d [BUF_BYTES];
  logic [BUF_CNT_W-1:0] fill_q;
  logic [BUF_CNT_W-1:0] chunk_size;
  logic [BUF_CNT_W-1:0] pop_n;
  logic [BUF_CNT_W-1:0] base;
  logic                 word_fire;
  logic                 can_pop;
  logic                 pop_full;
  logic                 pop_part;
  logic                 flush_q;
  logic                 flush_req;
  logic                 auto_expire;
  flush_cnt_t           idle_q;
  lane_vec_t            chunk_d;
  chan_mask_t           mask_d;
  lane_vec_t            chunk_q;
  chan_mask_t           mask_q;
  logic                 valid_q;

  // the chunk size is the number of enabled lanes
  always_comb begin
    chunk_size = '0;
    for (int i = 0; i < NUM_CHANNELS; i++) begin
      chunk_size = chunk_size + BUF_CNT_W'(tx_channel_en_i[i]);
    end
  end

  // a whole word must fit, so at most three bytes may be waiting
  assign word_ready_o = fill_q <= BUF_CNT_W'(BUF_BYTES - WORD_BYTES);
  assign word_fire    = word_valid_i & word_ready_o;

  // the output register can load when empty or being drained this cycle
  assign can_pop     = (!valid_q || chunk_ready_i) && (chunk_size != '0);
  assign flush_req   = tx_flush_i | flush_q;
  assign auto_expire = tx_auto_flush_en_i && (idle_q >= tx_auto_flush_count_i);
  assign pop_full    = can_pop && (fill_q >= chunk_size);
  // a leftover smaller than one chunk only goes out on a flush
  assign pop_part    = can_pop && !pop_full && (fill_q != '0) && (flush_req || auto_expire);
  assign pop_n       = pop_full ? chunk_size : (pop_part ? fill_q : '0);
  assign base        = fill_q - pop_n;

  always_comb begin
    for (int i = 0; i < BUF_BYTES; i++) begin
      // shift out the popped bytes, then append the new word behind the rest
      buf_d[i] = buf_q[i];
      if (i + pop_n < BUF_BYTES) begin
        buf_d[i] = buf_q[i + pop_n];
      end
      if (word_fire && (i >= base) && (i < base + WORD_BYTES)) begin
        buf_d[i] = word_i[LANE_W*(i - base) +: LANE_W];
      end
    end
    // the oldest bytes form the chunk, used positions are the low ones
    for (int k = 0; k < NUM_CHANNELS; k++) begin
      mask_d[k]  = k < pop_n;
      chunk_d[k] = (k < pop_n) ? buf_q[k] : '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fill_q  <= '0;
      idle_q  <= '0;
      flush_q <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      fill_q <= base + (word_fire ? BUF_CNT_W'(WORD_BYTES) : '0);
      // count idle cycles, saturating at the top
      if (word_fire) begin
        idle_q <= '0;
      end else if (idle_q != '1) begin
        idle_q <= idle_q + 1'b1;
      end
      // a manual flush waits until the leftover has actually gone out
      flush_q <= flush_req && !pop_part && (fill_q != '0);
      if (!valid_q || chunk_ready_i) begin
        valid_q <= pop_full | pop_part;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    buf_q <= buf_d;
    if (pop_full || pop_part) begin
      chunk_q <= chunk_d;
      mask_q  <= mask_d;
    end
  end

  assign chunk_o       = chunk_q;
  assign chunk_mask_o  = mask_q;
  assign chunk_valid_o = valid_q;

endmodule

// File: tx_spreader.sv
// ########################################
// the phy ready is treated as a barrier over every lane in use
// ########################################
`timescale 1ns/1ps

module tx_spreader
  import serial_alloc_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  chan_mask_t tx_channel_en_i,
  input  lane_vec_t  chunk_i,
  input  chan_mask_t chunk_mask_i,
  input  logic       chunk_valid_i,
  output logic       chunk_ready_o,
  output lane_vec_t  lane_data_o,
  output chan_mask_t lane_valid_o,
  input  chan_mask_t lane_ready_i
);

  logic [LANE_IDX_W-1:0] idx;
  lane_vec_t             spread_data;
  chan_mask_t            spread_valid;
  lane_vec_t             data_q;
  chan_mask_t            valid_q;
  logic                  all_ready;

  // compact byte n lands on the n-th enabled lane, counted from lane 0
  always_comb begin
    idx          = '0;
    spread_data  = '0;
    spread_valid = '0;
    for (int l = 0; l < NUM_CHANNELS; l++) begin
      if (tx_channel_en_i[l]) begin
        spread_data[l]  = chunk_i[idx];
        spread_valid[l] = chunk_mask_i[idx];
        idx             = idx + LANE_IDX_W'(1);
      end
    end
  end

  // the held chunk leaves only once every lane carrying a byte is ready
  assign all_ready     = (lane_ready_i & valid_q) == valid_q;
  assign chunk_ready_o = all_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (all_ready) begin
      valid_q <= chunk_valid_i ? spread_valid : '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (all_ready && chunk_valid_i) begin
      data_q <= spread_data;
    end
  end

  assign lane_data_o  = data_q;
  assign lane_valid_o = valid_q;

endmodule

// File: rx_lane_sync.sv
// ########################################
// lanes may be skewed by up to one cycle, the flush count must cover that skew
// with auto-flush off only complete transfers are captured
// ########################################
`timescale 1ns/1ps

module rx_lane_sync
  import serial_alloc_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  chan_mask_t rx_channel_en_i,
  input  logic       rx_auto_flush_en_i,
  input  flush_cnt_t rx_auto_flush_count_i,
  input  lane_vec_t  lane_data_i,
  input  chan_mask_t lane_valid_i,
  output chan_mask_t lane_ready_o,
  output lane_vec_t  slice_o,
  output chan_mask_t slice_mask_o,
  output logic       slice_valid_o,
  input  logic       slice_ready_i
);

  rx_sync_state_e state_q;
  rx_sync_state_e state_d;
  flush_cnt_t     cnt_q;
  flush_cnt_t     cnt_d;
  chan_mask_t     en_valid;
  logic           full_valid;
  logic           capture;
  logic           capture_fire;
  logic           bar_free;
  lane_vec_t      bar_data_q;
  chan_mask_t     bar_mask_q;
  logic           bar_valid_q;

  assign en_valid   = lane_valid_i & rx_channel_en_i;
  assign full_valid = (en_valid == rx_channel_en_i) && (en_valid != '0);

  // the barrier register accepts when empty or drained in this cycle
  assign bar_free     = !bar_valid_q || slice_ready_i;
  assign capture_fire = capture && bar_free;

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    capture = 1'b0;
    case (state_q)
      rx_wait: begin
        if (full_valid) begin
          capture = 1'b1;
        end else if ((en_valid != '0) && rx_auto_flush_en_i) begin
          // some lanes are early, give the others time to catch up
          state_d = rx_partial;
          cnt_d   = '0;
        end
      end
      rx_partial: begin
        // close the transfer on arrival of the rest or when the wait runs out
        if (full_valid || !rx_auto_flush_en_i || (cnt_q >= rx_auto_flush_count_i)) begin
          capture = 1'b1;
          if (bar_free) begin
            state_d = rx_wait;
            cnt_d   = '0;
          end
        end else begin
          cnt_d = cnt_q + 1'b1;
        end
      end
      default: begin
        state_d = rx_wait;
      end
    endcase
  end

  // only the lanes taken into the barrier are acknowledged
  assign lane_ready_o = capture_fire ? en_valid : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= rx_wait;
      cnt_q       <= '0;
      bar_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      if (capture_fire) begin
        bar_valid_q <= 1'b1;
      end else if (slice_ready_i) begin
        bar_valid_q <= 1'b0;
      end
    end
  end

  // the captured mask travels with the data so late lanes never merge in
  always_ff @(posedge clk_i) begin
    if (capture_fire) begin
      bar_data_q <= lane_data_i;
      bar_mask_q <= en_valid;
    end
  end

  assign slice_o       = bar_data_q;
  assign slice_mask_o  = bar_mask_q;
  assign slice_valid_o = bar_valid_q;

endmodule

// File: rx_despreader.sv
// ########################################
// inverse of the tx spreader, lane order is kept when packing
// ########################################
`timescale 1ns/1ps

module rx_despreader
  import serial_alloc_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  lane_vec_t  slice_i,
  input  chan_mask_t slice_mask_i,
  input  logic       slice_valid_i,
  output logic       slice_ready_o,
  output lane_vec_t  chunk_o,
  output chan_mask_t chunk_mask_o,
  output logic       chunk_valid_o,
  input  logic       chunk_ready_i
);

  logic [LANE_IDX_W-1:0] idx;
  lane_vec_t             packed_data;
  chan_mask_t            packed_mask;
  lane_vec_t             chunk_q;
  chan_mask_t            mask_q;
  logic                  valid_q;

  // every valid lane goes to the next free low position
  always_comb begin
    idx         = '0;
    packed_data = '0;
    packed_mask = '0;
    for (int l = 0; l < NUM_CHANNELS; l++) begin
      if (slice_mask_i[l]) begin
        packed_data[idx] = slice_i[l];
        packed_mask[idx] = 1'b1;
        idx              = idx + LANE_IDX_W'(1);
      end
    end
  end

  // stall while the output register holds a chunk nobody takes
  assign slice_ready_o = !valid_q || chunk_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (slice_ready_o) begin
      valid_q <= slice_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (slice_ready_o && slice_valid_i) begin
      chunk_q <= packed_data;
      mask_q  <= packed_mask;
    end
  end

  assign chunk_o       = chunk_q;
  assign chunk_mask_o  = mask_q;
  assign chunk_valid_o = valid_q;

endmodule

// File: rx_dechopper.sv
// ########################################
// expects compact chunks whose mask has only low bits set
// ########################################
`timescale 1ns/1ps

module rx_dechopper
  import serial_alloc_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  lane_vec_t  chunk_i,
  input  chan_mask_t chunk_mask_i,
  input  logic       chunk_valid_i,
  output logic       chunk_ready_o,
  output link_word_t word_o,
  output logic       word_valid_o,
  input  logic       word_ready_i
);

  lane_t                buf_q [BUF_BYTES];
  lane_t                buf_d [BUF_BYTES];
  logic [BUF_CNT_W-1:0] fill_q;
  logic [BUF_CNT_W-1:0] chunk_cnt;
  logic [BUF_CNT_W-1:0] pop_n;
  logic [BUF_CNT_W-1:0] base;
  logic [BUF_CNT_W:0]   need_fill;
  logic                 pop;
  logic                 push;
  link_word_t           word_q;
  logic                 valid_q;

  // number of bytes carried by the incoming chunk
  always_comb begin
    chunk_cnt = '0;
    for (int i = 0; i < NUM_CHANNELS; i++) begin
      chunk_cnt = chunk_cnt + BUF_CNT_W'(chunk_mask_i[i]);
    end
  end

  // a word is taken from the buffer once four bytes have gathered
  assign pop   = (!valid_q || word_ready_i) && (fill_q >= BUF_CNT_W'(WORD_BYTES));
  assign pop_n = pop ? BUF_CNT_W'(WORD_BYTES) : '0;
  assign base  = fill_q - pop_n;

  // refuse a chunk that would not fit after this cycle's pop
  assign need_fill     = {1'b0, base} + {1'b0, chunk_cnt};
  assign chunk_ready_o = need_fill <= (BUF_CNT_W + 1)'(BUF_BYTES);
  assign push          = chunk_valid_i && chunk_ready_o;

  always_comb begin
    for (int i = 0; i < BUF_BYTES; i++) begin
      // excess bytes move down and the new chunk lands behind them
      buf_d[i] = buf_q[i];
      if (i + pop_n < BUF_BYTES) begin
        buf_d[i] = buf_q[i + pop_n];
      end
      if (push && (i >= base) && (i < base + chunk_cnt)) begin
        buf_d[i] = chunk_i[i - base];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fill_q  <= '0;
      valid_q <= 1'b0;
    end else begin
      fill_q <= base + (push ? chunk_cnt : '0);
      if (!valid_q || word_ready_i) begin
        valid_q <= pop;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    buf_q <= buf_d;
    // the oldest byte becomes the least significant one
    if (pop) begin
      for (int b = 0; b < WORD_BYTES; b++) begin
        word_q[LANE_W*b +: LANE_W] <= buf_q[b];
      end
    end
  end

  assign word_o       = word_q;
  assign word_valid_o = valid_q;

endmodule

// File: serial_alloc_top.sv
// ########################################
// tx and rx share nothing but the clock and reset
// both flush counts are in core clock cycles
// ########################################
`timescale 1ns/1ps

module serial_alloc_top
  import serial_alloc_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  // tx configuration
  input  chan_mask_t tx_channel_en_i,
  input  logic       tx_auto_flush_en_i,
  input  flush_cnt_t tx_auto_flush_count_i,
  input  logic       tx_flush_i,
  // rx configuration
  input  chan_mask_t rx_channel_en_i,
  input  logic       rx_auto_flush_en_i,
  input  flush_cnt_t rx_auto_flush_count_i,
  // link layer transmit side
  input  link_word_t tx_word_i,
  input  logic       tx_word_valid_i,
  output logic       tx_word_ready_o,
  // phy transmit lanes
  output lane_vec_t  tx_lane_data_o,
  output chan_mask_t tx_lane_valid_o,
  input  chan_mask_t tx_lane_ready_i,
  // phy receive lanes
  input  lane_vec_t  rx_lane_data_i,
  input  chan_mask_t rx_lane_valid_i,
  output chan_mask_t rx_lane_ready_o,
  // link layer receive side
  output link_word_t rx_word_o,
  output logic       rx_word_valid_o,
  input  logic       rx_word_ready_i
);

  // chopper to spreader
  lane_vec_t  tx_chunk;
  chan_mask_t tx_chunk_mask;
  logic       tx_chunk_valid;
  logic       tx_chunk_ready;
  // lane sync to despreader
  lane_vec_t  rx_slice;
  chan_mask_t rx_slice_mask;
  logic       rx_slice_valid;
  logic       rx_slice_ready;
  // despreader to dechopper
  lane_vec_t  rx_chunk;
  chan_mask_t rx_chunk_mask;
  logic       rx_chunk_valid;
  logic       rx_chunk_ready;

  tx_chopper i_tx_chopper (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .tx_channel_en_i       (tx_channel_en_i),
    .tx_auto_flush_en_i    (tx_auto_flush_en_i),
    .tx_auto_flush_count_i (tx_auto_flush_count_i),
    .tx_flush_i            (tx_flush_i),
    .word_i                (tx_word_i),
    .word_valid_i          (tx_word_valid_i),
    .word_ready_o          (tx_word_ready_o),
    .chunk_o               (tx_chunk),
    .chunk_mask_o          (tx_chunk_mask),
    .chunk_valid_o         (tx_chunk_valid),
    .chunk_ready_i         (tx_chunk_ready)
  );

  tx_spreader i_tx_spreader (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .tx_channel_en_i (tx_channel_en_i),
    .chunk_i         (tx_chunk),
    .chunk_mask_i    (tx_chunk_mask),
    .chunk_valid_i   (tx_chunk_valid),
    .chunk_ready_o   (tx_chunk_ready),
    .lane_data_o     (tx_lane_data_o),
    .lane_valid_o    (tx_lane_valid_o),
    .lane_ready_i    (tx_lane_ready_i)
  );

  rx_lane_sync i_rx_lane_sync (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .rx_channel_en_i       (rx_channel_en_i),
    .rx_auto_flush_en_i    (rx_auto_flush_en_i),
    .rx_auto_flush_count_i (rx_auto_flush_count_i),
    .lane_data_i           (rx_lane_data_i),
    .lane_valid_i          (rx_lane_valid_i),
    .lane_ready_o          (rx_lane_ready_o),
    .slice_o               (rx_slice),
    .slice_mask_o          (rx_slice_mask),
    .slice_valid_o         (rx_slice_valid),
    .slice_ready_i         (rx_slice_ready)
  );

  rx_despreader i_rx_despreader (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .slice_i       (rx_slice),
    .slice_mask_i  (rx_slice_mask),
    .slice_valid_i (rx_slice_valid),
    .slice_ready_o (rx_slice_ready),
    .chunk_o       (rx_chunk),
    .chunk_mask_o  (rx_chunk_mask),
    .chunk_valid_o (rx_chunk_valid),
    .chunk_ready_i (rx_chunk_ready)
  );

  rx_dechopper i_rx_dechopper (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .chunk_i       (rx_chunk),
    .chunk_mask_i  (rx_chunk_mask),
    .chunk_valid_i (rx_chunk_valid),
    .chunk_ready_o (rx_chunk_ready),
    .word_o        (rx_word_o),
    .word_valid_o  (rx_word_valid_o),
    .word_ready_i  (rx_word_ready_i)
  );

endmodule

// File: tb_clock_gen.sv
// ########################################
// 40 ns clock, reset held low for four cycles
// reset is released 2 ns after a rising edge
// ########################################
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam real HALF_PERIOD_NS = 20.0;
  localparam int  RESET_CYCLES   = 4;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  // release away from the edge so no register sees it change at the edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2;
    rst_no = 1'b1;
  end

endmodule

// File: tb_serial_alloc.sv
// ########################################
// tx lanes loop back to rx lanes and lane 3 can lag by one cycle
// tx and rx always use the same lane mask
// ########################################
`timescale 1ns/1ps

module tb_serial_alloc
  import serial_alloc_pkg::*;
();

  localparam int unsigned SEED         = 32'h8aba6edd;
  localparam int          TOTAL_WORDS  = 8 + 12 + 1 + 1 + 12 + 20;
  localparam int          WDOG_CYCLES  = 200 * TOTAL_WORDS + 2000;
  localparam int          DRAIN_CYCLES = 400;

  logic       clk;
  logic       rst_n;
  chan_mask_t tx_channel_en;
  logic       tx_auto_flush_en;
  flush_cnt_t tx_auto_flush_count;
  logic       tx_flush;
  chan_mask_t rx_channel_en;
  logic       rx_auto_flush_en;
  flush_cnt_t rx_auto_flush_count;
  link_word_t tx_word;
  logic       tx_word_valid;
  logic       tx_word_ready;
  lane_vec_t  tx_lane_data;
  chan_mask_t tx_lane_valid;
  chan_mask_t tx_lane_ready;
  lane_vec_t  rx_lane_data;
  chan_mask_t rx_lane_valid;
  chan_mask_t rx_lane_ready;
  link_word_t rx_word;
  logic       rx_word_valid;
  logic       rx_word_ready;

  // state of the loopback model where lane 3 is the one that can lag
  logic        skew_en;
  logic        lane3_pending;
  logic        lane3_late;
  link_word_t  exp_q[$];
  link_word_t  exp_word;
  lane_t       tx_byte_q[$];
  lane_t       exp_byte;
  int          rx_count;
  int          errors;
  int          checks;
  int          tests_run;
  int unsigned seed_val;

  tb_clock_gen i_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  serial_alloc_top uut (
    .clk_i                 (clk),
    .rst_ni                (rst_n),
    .tx_channel_en_i       (tx_channel_en),
    .tx_auto_flush_en_i    (tx_auto_flush_en),
    .tx_auto_flush_count_i (tx_auto_flush_count),
    .tx_flush_i            (tx_flush),
    .rx_channel_en_i       (rx_channel_en),
    .rx_auto_flush_en_i    (rx_auto_flush_en),
    .rx_auto_flush_count_i (rx_auto_flush_count),
    .tx_word_i             (tx_word),
    .tx_word_valid_i       (tx_word_valid),
    .tx_word_ready_o       (tx_word_ready),
    .tx_lane_data_o        (tx_lane_data),
    .tx_lane_valid_o       (tx_lane_valid),
    .tx_lane_ready_i       (tx_lane_ready),
    .rx_lane_data_i        (rx_lane_data),
    .rx_lane_valid_i       (rx_lane_valid),
    .rx_lane_ready_o       (rx_lane_ready),
    .rx_word_o             (rx_word),
    .rx_word_valid_o       (rx_word_valid),
    .rx_word_ready_i       (rx_word_ready)
  );

  // lane 3 only shows up at rx once it has been presented for a full cycle
  assign rx_lane_data  = tx_lane_data;
  assign rx_lane_valid = {tx_lane_valid[3] & (lane3_late | ~skew_en), tx_lane_valid[2:0]};
  assign tx_lane_ready = rx_lane_ready;

  // a lane 3 byte not taken at the coming edge is late from then on
  always @(negedge clk) begin
    lane3_pending = skew_en && tx_lane_valid[3] && !rx_lane_ready[3];
  end

  always @(posedge clk) begin
    #2;
    lane3_late = lane3_pending;
  end

  task automatic check_word(input string name, input link_word_t got, input link_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_mask(input string name, input chan_mask_t got, input chan_mask_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%01h, expected 0x%01h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_byte(input string name, input lane_t got, input lane_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%02h, expected 0x%02h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%01h, expected 0x%01h at %0t", name, got, exp, $time);
    end
  endtask

  // sampled mid-cycle where every output and handshake is settled
  always @(negedge clk) begin
    if (rst_n) begin
      // a lane that is switched off must never carry a byte
      check_mask("tx_lane_valid_o on disabled lanes", tx_lane_valid & ~tx_channel_en, '0);
      // bytes leave in send order spread over the lanes from lane 0 upwards
      if ((tx_lane_valid != '0) && ((tx_lane_ready & tx_lane_valid) == tx_lane_valid)) begin
        for (int l = 0; l < NUM_CHANNELS; l++) begin
          if (tx_lane_valid[l]) begin
            if (tx_byte_q.size() == 0) begin
              errors++;
              $display("tx lane %0d sent byte 0x%02h with none outstanding at %0t",
                       l, tx_lane_data[l], $time);
            end else begin
              exp_byte = tx_byte_q.pop_front();
              check_byte($sformatf("tx_lane_data_o[%0d]", l), tx_lane_data[l], exp_byte);
            end
          end
        end
      end
      if (rx_word_valid && rx_word_ready) begin
        rx_count++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("unexpected rx word 0x%08h arrived with none outstanding at %0t",
                   rx_word, $time);
        end else begin
          exp_word = exp_q.pop_front();
          check_word("rx_word_o", rx_word, exp_word);
        end
      end
    end
  end

  initial begin
    repeat (WDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, %0d words still outstanding",
             WDOG_CYCLES, exp_q.size());
    $display("RESULT: FAIL");
    $finish;
  end

  // all calls start and end 2 ns after a rising edge
  task automatic configure_link(input chan_mask_t mask, input logic tx_auto,
                                input logic rx_auto, input logic skew);
    tx_channel_en    = mask;
    rx_channel_en    = mask;
    tx_auto_flush_en = tx_auto;
    rx_auto_flush_en = rx_auto;
    skew_en          = skew;
    rx_word_ready    = 1'b1;
    @(posedge clk);
    #2;
  endtask

  task automatic send_words(input int n);
    link_word_t w;
    for (int i = 0; i < n; i++) begin
      w             = link_word_t'($urandom);
      tx_word       = w;
      tx_word_valid = 1'b1;
      @(negedge clk);
      while (!tx_word_ready) begin
        @(negedge clk);
      end
      // the word is taken at the coming edge
      exp_q.push_back(w);
      for (int b = 0; b < WORD_BYTES; b++) begin
        tx_byte_q.push_back(w[LANE_W*b +: LANE_W]);
      end
      @(posedge clk);
      #2;
    end
    tx_word_valid = 1'b0;
  endtask

  task automatic wait_drained(input int max_cycles);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < max_cycles) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d words still missing after %0d cycles", exp_q.size(), max_cycles);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    $display("test %0d %s: %s, %0d errors", tests_run, name,
             (errors == err_before) ? "ok" : "bad", errors - err_before);
  endtask

  task automatic all_lanes_loopback();
    int err0;
    err0 = errors;
    configure_link(4'b1111, 1'b0, 1'b1, 1'b0);
    send_words(8);
    wait_drained(DRAIN_CYCLES);
    report_test("four lanes", err0);
  endtask

  task automatic sparse_mask_loopback();
    int err0;
    err0 = errors;
    // with lane 2 off the chunks are three bytes wide
    configure_link(4'b1011, 1'b0, 1'b1, 1'b0);
    send_words(12);
    wait_drained(DRAIN_CYCLES);
    report_test("lane mask 1011", err0);
  endtask

  task automatic auto_flush_single_word();
    int err0;
    err0 = errors;
    // one byte is left over and must leave on the idle timeout
    configure_link(4'b0111, 1'b1, 1'b1, 1'b0);
    send_words(1);
    wait_drained(DRAIN_CYCLES);
    report_test("auto flush", err0);
  endtask

  task automatic manual_flush_single_word();
    int err0;
    int seen;
    err0 = errors;
    configure_link(4'b0111, 1'b0, 1'b1, 1'b0);
    seen = rx_count;
    send_words(1);
    repeat (50) begin
      @(posedge clk);
      #2;
    end
    checks++;
    if (rx_count != seen) begin
      errors++;
      $display("a word arrived before the manual flush was given");
    end
    tx_flush = 1'b1;
    @(posedge clk);
    #2;
    tx_flush = 1'b0;
    wait_drained(DRAIN_CYCLES);
    report_test("manual flush", err0);
  endtask

  task automatic skewed_lane_loopback();
    int err0;
    err0 = errors;
    configure_link(4'b1111, 1'b0, 1'b1, 1'b1);
    send_words(12);
    wait_drained(DRAIN_CYCLES);
    skew_en = 1'b0;
    report_test("lane 3 skew", err0);
  endtask

  // a long stall fills the whole path before random stretches of ready follow
  task automatic hold_off_link();
    int low_n;
    int high_n;
    rx_word_ready = 1'b0;
    repeat (80) begin
      @(posedge clk);
      #2;
    end
    @(negedge clk);
    check_flag("tx_word_ready_o", tx_word_ready, 1'b0);
    check_mask("rx_lane_ready_o", rx_lane_ready, '0);
    @(posedge clk);
    #2;
    repeat (30) begin
      low_n  = $urandom % 7;
      high_n = $urandom % 5 + 1;
      rx_word_ready = 1'b0;
      repeat (low_n) begin
        @(posedge clk);
        #2;
      end
      rx_word_ready = 1'b1;
      repeat (high_n) begin
        @(posedge clk);
        #2;
      end
    end
    rx_word_ready = 1'b1;
  endtask

  task automatic backpressure_stream();
    int err0;
    err0 = errors;
    configure_link(4'b1111, 1'b0, 1'b1, 1'b0);
    fork
      send_words(20);
      hold_off_link();
    join
    wait_drained(DRAIN_CYCLES);
    report_test("back-pressure", err0);
  endtask

  initial begin
    seed_val            = $urandom(SEED);
    tx_channel_en       = 4'b1111;
    tx_auto_flush_en    = 1'b0;
    tx_auto_flush_count = 8'd4;
    tx_flush            = 1'b0;
    rx_channel_en       = 4'b1111;
    rx_auto_flush_en    = 1'b1;
    rx_auto_flush_count = 8'd4;
    tx_word             = '0;
    tx_word_valid       = 1'b0;
    rx_word_ready       = 1'b1;
    skew_en             = 1'b0;
    lane3_pending       = 1'b0;
    lane3_late          = 1'b0;
    rx_count            = 0;
    errors              = 0;
    checks              = 0;
    tests_run           = 0;
    wait (rst_n === 1'b1);
    @(posedge clk);
    #2;
    all_lanes_loopback();
    sparse_mask_loopback();
    auto_flush_single_word();
    manual_flush_single_word();
    skewed_lane_loopback();
    backpressure_stream();
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: serial_alloc.f
serial_alloc_pkg.sv
tx_chopper.sv
tx_spreader.sv
rx_lane_sync.sv
rx_despreader.sv
rx_dechopper.sv
serial_alloc_top.sv
tb_clock_gen.sv
tb_serial_alloc.sv
